// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fp_noncomp_slice
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh sim/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BINARY)
	@./$(BINARY) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/fpu_slice_params.svh ====
`ifndef FPU_SLICE_PARAMS_SVH
`define FPU_SLICE_PARAMS_SVH

// Datapath width of the slice
`define SLICE_WIDTH 32

// Lanes side by side, two FP16 lanes fit one word
`define NUM_LANES 2

// Register stages inside every lane
`define NUM_PIPE_REGS 2

// Width of the tag that travels with lane 0
`define TAG_WIDTH 4

`endif

// ==== sim/slice_assert.sv ====
`timescale 1ns/1ps

`include "fpu_slice_params.svh"

module slice_assert (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    flush_i,
  input logic                    out_ready_i,
  input logic                    out_valid_i,
  input logic                    busy_i,
  input fp_fmt_pkg::fp_word_u    result_i,
  input fp_fmt_pkg::fp_status_t  status_i,
  input logic [`TAG_WIDTH-1:0]   tag_i
);

  // A stalled result holds until taken, a flush may drop it
  hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i && !flush_i |=>
      out_valid_i && $stable(result_i) && $stable(status_i) && $stable(tag_i))
    else $error("Stalled result changed or was dropped");

  valid_means_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i |-> busy_i)
    else $error("out_valid_o high while busy_o low");

  no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else $error("out_valid_o high during reset");

endmodule

bind fp_noncomp_slice slice_assert i_slice_assert (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .flush_i     ( flush_i     ),
  .out_ready_i ( out_ready_i ),
  .out_valid_i ( out_valid_o ),
  .busy_i      ( busy_o      ),
  .result_i    ( result_o    ),
  .status_i    ( status_o    ),
  .tag_i       ( tag_o       )
);

// ==== sim/tb_slice_tasks.svh ====
// ----------------------------------------------------------------------------
// Handshake
// ----------------------------------------------------------------------------

// Starts on a rising edge and returns on the edge that accepts the operation
task automatic issue(input fp_fmt_pkg::fp_word_u a, input fp_fmt_pkg::fp_word_u b,
                     input fp_op_pkg::noncomp_op_e op, input fp_fmt_pkg::fp_format_e fmt,
                     input logic vec, input logic [`TAG_WIDTH-1:0] tag);
  int n;
  operand_a_i    <= a;
  operand_b_i    <= b;
  op_i           <= op;
  fmt_i          <= fmt;
  vectorial_op_i <= vec;
  tag_i          <= tag;
  in_valid_i     <= 1'b1;
  n = 0;
  do begin
    @(negedge clk_i);
    n++;
  end while (!in_ready_o && n < TimeoutCycles);
  if (!in_ready_o) begin
    $display("Operation with tag %0d was not accepted within %0d cycles", tag, TimeoutCycles);
    errors++;
  end
  @(posedge clk_i);
  in_valid_i <= 1'b0;
endtask

task automatic wait_result(output fp_fmt_pkg::fp_word_u r, output fp_fmt_pkg::fp_status_t st,
                           output logic [`TAG_WIDTH-1:0] tag, output bit got);
  got = 1'b0;
  for (int n = 0; n < TimeoutCycles && !got; n++) begin
    @(negedge clk_i);
    got = out_valid_o;
  end
  r   = result_o;  // Sampled mid-cycle
  st  = status_o;
  tag = tag_o;
  if (!got) begin
    $display("No result arrived within %0d cycles", TimeoutCycles);
    errors++;
  end
  @(posedge clk_i);
endtask

// ----------------------------------------------------------------------------
// Compare
// ----------------------------------------------------------------------------
task automatic check_word(input fp_fmt_pkg::fp_word_u exp, input fp_fmt_pkg::fp_word_u act,
                          input string what);
  if (act !== exp) begin
    $display("Error at %0t: %s result expected %h, got %h", $time, what, exp, act);
    errors++;
  end
endtask

task automatic check_status(input fp_fmt_pkg::fp_status_t exp,
                            input fp_fmt_pkg::fp_status_t act, input string what);
  if (act !== exp) begin
    $display("Error at %0t: %s status expected %b, got %b", $time, what, exp, act);
    errors++;
  end
endtask

task automatic check_tag(input logic [`TAG_WIDTH-1:0] exp, input logic [`TAG_WIDTH-1:0] act,
                         input string what);
  if (act !== exp) begin
    $display("Error at %0t: %s tag expected %0d, got %0d", $time, what, exp, act);
    errors++;
  end
endtask

task automatic run_op(input logic [31:0] a, input logic [31:0] b,
                      input fp_op_pkg::noncomp_op_e op, input fp_fmt_pkg::fp_format_e fmt,
                      input logic vec, input string what);
  fp_fmt_pkg::fp_word_u   exp_word, got_word;
  fp_fmt_pkg::fp_status_t exp_status, got_status;
  logic [`TAG_WIDTH-1:0]  exp_tag, got_tag;
  bit                     got;
  slice_model(a, b, op, fmt, vec, exp_word, exp_status);
  exp_tag = tag_counter;
  tag_counter++;
  issue(a, b, op, fmt, vec, exp_tag);
  wait_result(got_word, got_status, got_tag, got);
  if (got) begin
    check_word(exp_word, got_word, what);
    check_status(exp_status, got_status, what);
    check_tag(exp_tag, got_tag, what);
  end
endtask

task automatic finish_test(input string name, input int start_errors);
  tests++;
  $display("Test %s done, %0d errors", name, errors - start_errors);
endtask

// ----------------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------------
task automatic sign_inject_fp32();
  int start;
  start = errors;
  run_op(32'h3F80_0000, 32'hC000_0000, fp_op_pkg::SGNJ, fp_fmt_pkg::FP32, 1'b0, "sgnj");
  run_op(32'h3F80_0000, 32'hC000_0000, fp_op_pkg::SGNJN, fp_fmt_pkg::FP32, 1'b0, "sgnjn");
  run_op(32'hBF80_0000, 32'hC000_0000, fp_op_pkg::SGNJX, fp_fmt_pkg::FP32, 1'b0, "sgnjx");
  run_op(32'h7FA1_2345, 32'h8000_0000, fp_op_pkg::SGNJ, fp_fmt_pkg::FP32, 1'b0, "sgnj nan");
  run_op(32'hFFC0_0001, 32'h0000_0001, fp_op_pkg::SGNJX, fp_fmt_pkg::FP32, 1'b0, "sgnjx nan");
  finish_test("sign injection FP32", start);
endtask

task automatic vector_min_max();
  int start;
  start = errors;
  // Low half NaN against 1.0 and high half -0 against +0
  run_op({16'h8000, 16'h7E00}, {16'h0000, 16'h3C00}, fp_op_pkg::FMIN, fp_fmt_pkg::FP16, 1'b1,
         "vector fmin");
  run_op({16'h8000, 16'h7E00}, {16'h0000, 16'h3C00}, fp_op_pkg::FMAX, fp_fmt_pkg::FP16, 1'b1,
         "vector fmax");
  run_op({16'h7C01, 16'h4000}, {16'h3800, 16'hC000}, fp_op_pkg::FMIN, fp_fmt_pkg::FP16, 1'b1,
         "upper snan");  // Signaling NaN only in lane 1
  finish_test("vectorial FP16 min/max", start);
endtask

task automatic scalar_boxing();
  int start;
  start = errors;
  run_op({16'h1234, 16'h3C00}, {16'h5678, 16'hBC00}, fp_op_pkg::SGNJ, fp_fmt_pkg::FP16, 1'b0,
         "scalar fp16 sgnj");
  run_op({16'hABCD, 16'h7D00}, {16'h0000, 16'h4200}, fp_op_pkg::FMIN, fp_fmt_pkg::FP16, 1'b0,
         "scalar fp16 snan");
  // Upper half of A reads as an FP16 signaling NaN
  run_op(32'h7D00_0FDB, 32'hC000_0000, fp_op_pkg::FMAX, fp_fmt_pkg::FP32, 1'b1,
         "fp32 with vectorial");
  finish_test("scalar boxing", start);
endtask

task automatic back_pressure();
  fp_fmt_pkg::fp_word_u   exp_q[$];
  logic [`TAG_WIDTH-1:0]  tag_q[$];
  fp_fmt_pkg::fp_word_u   r;
  fp_fmt_pkg::fp_status_t s;
  logic [`TAG_WIDTH-1:0]  t;
  logic [31:0]            a;
  bit                     got;
  int                     n, start;
  start = errors;
  out_ready_i <= 1'b0;
  for (n = 0; n < 8; n++) begin
    @(negedge clk_i);
    if (!in_ready_o) break;
    @(posedge clk_i);
    a = {16'h4000 + 16'(n), 16'h3C00 + 16'(n)};
    slice_model(a, 32'h0, fp_op_pkg::FMAX, fp_fmt_pkg::FP16, 1'b1, r, s);
    exp_q.push_back(r);
    tag_q.push_back(tag_counter);
    issue(a, 32'h0, fp_op_pkg::FMAX, fp_fmt_pkg::FP16, 1'b1, tag_counter);
    tag_counter++;
  end
  if (n != `NUM_PIPE_REGS) begin
    $display("in_ready_o fell after %0d operations instead of %0d", n, `NUM_PIPE_REGS);
    errors++;
  end
  @(posedge clk_i);
  out_ready_i <= 1'b1;
  while (exp_q.size() > 0) begin
    wait_result(r, s, t, got);
    if (!got) break;
    check_word(exp_q.pop_front(), r, "queued");
    check_tag(tag_q.pop_front(), t, "queued");
  end
  @(negedge clk_i);
  if (out_valid_o) begin
    $display("An extra result appeared after the queued results drained");
    errors++;
  end
  @(posedge clk_i);
  finish_test("back-pressure", start);
endtask

task automatic flush_drops();
  bit seen;
  int start;
  start = errors;
  seen  = 1'b0;
  out_ready_i <= 1'b0;
  issue(32'h3F80_0000, 32'h4000_0000, fp_op_pkg::FMIN, fp_fmt_pkg::FP32, 1'b0, tag_counter);
  issue(32'h3C00_4000, 32'h4000_3C00, fp_op_pkg::FMAX, fp_fmt_pkg::FP16, 1'b1, tag_counter);
  flush_i <= 1'b1;
  @(posedge clk_i);
  flush_i     <= 1'b0;
  out_ready_i <= 1'b1;
  for (int n = 0; n < TimeoutCycles; n++) begin
    @(negedge clk_i);
    seen |= out_valid_o;
  end
  if (seen) begin
    $display("A result appeared after the flush");
    errors++;
  end
  if (busy_o) begin
    $display("busy_o stayed high after the flush");
    errors++;
  end
  @(posedge clk_i);
  finish_test("flush", start);
endtask

// Random value with a quarter of them given an all-ones exponent
function automatic logic [15:0] rand_half();
  logic [15:0] v;
  v = 16'($urandom);
  if ($urandom_range(3) == 0) v[14:10] = '1;
  return v;
endfunction

function automatic logic [31:0] rand_single();
  logic [31:0] v;
  v = $urandom;
  if ($urandom_range(3) == 0) v[30:23] = '1;
  return v;
endfunction

task automatic random_min_max();
  fp_op_pkg::noncomp_op_e op;
  int                     start;
  start = errors;
  for (int i = 0; i < 50; i++) begin
    op = ($urandom_range(1) == 1) ? fp_op_pkg::FMAX : fp_op_pkg::FMIN;
    if (i % 2 == 1) begin
      run_op({rand_half(), rand_half()}, {rand_half(), rand_half()}, op, fp_fmt_pkg::FP16,
             1'b1, "random fp16");
    end else begin
      run_op(rand_single(), rand_single(), op, fp_fmt_pkg::FP32, 1'b0, "random fp32");
    end
  end
  finish_test("random min/max", start);
endtask

// ==== sim/tb_fp_noncomp_slice.sv ====
`timescale 1ns/1ps

`include "fpu_slice_params.svh"

module tb_fp_noncomp_slice;

  localparam int TimeoutCycles = 20;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  fp_fmt_pkg::fp_word_u    operand_a_i, operand_b_i;
  fp_op_pkg::noncomp_op_e  op_i;
  fp_fmt_pkg::fp_format_e  fmt_i;
  logic                    vectorial_op_i;
  logic [`TAG_WIDTH-1:0]   tag_i;
  logic                    in_valid_i, flush_i, out_ready_i;
  logic                    in_ready_o, out_valid_o, busy_o;
  fp_fmt_pkg::fp_word_u    result_o;
  fp_fmt_pkg::fp_status_t  status_o;
  logic [`TAG_WIDTH-1:0]   tag_o;

  int                      errors = 0;
  int                      tests = 0;
  logic [`TAG_WIDTH-1:0]   tag_counter = '0;  // Next tag to issue

  always #2 clk_i = ~clk_i;

  fp_noncomp_slice dut_i (.*);

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // One element as FP32 when wide is set and as FP16 in the low 16 bits otherwise
  function automatic void lane_model(input logic [31:0] a, input logic [31:0] b,
                                     input fp_op_pkg::noncomp_op_e op, input bit wide,
                                     output logic [31:0] r, output logic nv);
    int          sb;
    logic [31:0] mask;
    logic [32:0] ka, kb;
    logic        sa, sgb, na, nb, qa, qb, a_less;
    sb   = wide ? 31 : 15;
    mask = wide ? 32'h7FFF_FFFF : 32'h0000_7FFF;
    sa   = a[sb];
    sgb  = b[sb];
    na   = wide ? (&a[30:23] && |a[22:0]) : (&a[14:10] && |a[9:0]);
    nb   = wide ? (&b[30:23] && |b[22:0]) : (&b[14:10] && |b[9:0]);
    qa   = wide ? a[22] : a[9];  // Quiet bit
    qb   = wide ? b[22] : b[9];
    nv   = 1'b0;
    r    = a;
    case (op)
      fp_op_pkg::SGNJ:  r[sb] = sgb;
      fp_op_pkg::SGNJN: r[sb] = ~sgb;
      fp_op_pkg::SGNJX: r[sb] = sa ^ sgb;
      default: begin
        nv = (na && !qa) || (nb && !qb);
        // Place each value on one number line where -0 sits just below +0
        ka     = sa ? 33'(mask & ~a) : 33'(mask) + 33'(a & mask) + 33'd1;
        kb     = sgb ? 33'(mask & ~b) : 33'(mask) + 33'(b & mask) + 33'd1;
        a_less = ka < kb;
        if (na && nb) begin
          r = wide ? fp_fmt_pkg::QNAN_FP32 : {16'h0000, fp_fmt_pkg::QNAN_FP16};
        end else if (na) begin
          r = b;
        end else if (nb) begin
          r = a;
        end else begin
          r = ((op == fp_op_pkg::FMIN) == a_less) ? a : b;
        end
      end
    endcase
  endfunction

  function automatic void slice_model(input logic [31:0] a, input logic [31:0] b,
                                      input fp_op_pkg::noncomp_op_e op,
                                      input fp_fmt_pkg::fp_format_e fmt, input logic vec,
                                      output fp_fmt_pkg::fp_word_u r,
                                      output fp_fmt_pkg::fp_status_t st);
    logic [31:0] lo, hi;
    logic        nv_lo, nv_hi;
    st = '0;
    if (fmt == fp_fmt_pkg::FP32) begin
      lane_model(a, b, op, 1'b1, lo, nv_lo);
      r     = lo;
      st.nv = nv_lo;
    end else begin
      lane_model({16'h0000, a[15:0]}, {16'h0000, b[15:0]}, op, 1'b0, lo, nv_lo);
      lane_model({16'h0000, a[31:16]}, {16'h0000, b[31:16]}, op, 1'b0, hi, nv_hi);
      r     = {vec ? hi[15:0] : 16'hFFFF, lo[15:0]};  // Scalar result is NaN-boxed
      st.nv = nv_lo | (vec & nv_hi);
    end
  endfunction

  `include "tb_slice_tasks.svh"

  initial begin
    void'($urandom(43253));
    rst_n_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = fp_op_pkg::SGNJ;
    fmt_i          = fp_fmt_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    if (out_valid_o || busy_o || !in_ready_o) begin
      $display("Handshake outputs were not idle after reset");
      errors++;
    end
    @(posedge clk_i);
    sign_inject_fp32();
    vector_min_max();
    scalar_boxing();
    back_pressure();
    flush_drops();
    random_min_max();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
+incdir+sim
verilog/fp_fmt_pkg.sv
verilog/fp_op_pkg.sv
verilog/lane_pipeline.sv
verilog/noncomp_lane.sv
verilog/result_packer.sv
verilog/fp_noncomp_slice.sv
sim/slice_assert.sv
sim/tb_fp_noncomp_slice.sv

// ==== verilog/fp_fmt_pkg.sv ====
package fp_fmt_pkg;

  // --------------------------------------------------------------------------
  // Formats
  // --------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } fp16_t;

  // One datapath word, seen as a single FP32 or as two FP16 halves
  typedef union packed {
    fp32_t           single;
    fp16_t [1:0]     half;    // Element 0 is the low half
  } fp_word_u;

  // --------------------------------------------------------------------------
  // Status flags, same order as the RISC-V fflags
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fp_status_t;

  // Canonical quiet NaNs
  localparam logic [31:0] QNAN_FP32 = 32'h7FC0_0000;
  localparam logic [15:0] QNAN_FP16 = 16'h7E00;

endpackage

// ==== verilog/fp_noncomp_slice.sv ====
`timescale 1ns/1ps

`include "fpu_slice_params.svh"

module fp_noncomp_slice (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fp_fmt_pkg::fp_word_u     operand_a_i,
  input  fp_fmt_pkg::fp_word_u     operand_b_i,
  input  fp_op_pkg::noncomp_op_e   op_i,
  input  fp_fmt_pkg::fp_format_e   fmt_i,
  input  logic                     vectorial_op_i,
  input  logic [`TAG_WIDTH-1:0]    tag_i,
  input  logic                     in_valid_i,
  input  logic                     flush_i,
  input  logic                     out_ready_i,
  output logic                     in_ready_o,
  output fp_fmt_pkg::fp_word_u     result_o,
  output fp_fmt_pkg::fp_status_t   status_o,
  output logic [`TAG_WIDTH-1:0]    tag_o,
  output logic                     out_valid_o,
  output logic                     busy_o
);

  logic                                        vectorial_op;
  fp_op_pkg::slice_aux_t                       in_aux, lane0_aux;
  fp_fmt_pkg::fp_word_u                        lane1_op_a, lane1_op_b;
  logic                                        lane1_in_valid, lane1_out_ready;
  fp_fmt_pkg::fp_word_u   [`NUM_LANES-1:0]     lane_result;
  fp_fmt_pkg::fp_status_t [`NUM_LANES-1:0]     lane_status;
  logic                   [`NUM_LANES-1:0]     lane_out_valid, lane_busy;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  assign vectorial_op = vectorial_op_i & (fmt_i == fp_fmt_pkg::FP16);  // Only FP16 splits
  assign in_aux       = '{fmt: fmt_i, vectorial: vectorial_op, tag: tag_i};

  // Lane 1 sees the upper FP16 element in its low half
  assign lane1_op_a     = {16'h0000, operand_a_i.half[1]};
  assign lane1_op_b     = {16'h0000, operand_b_i.half[1]};
  assign lane1_in_valid = in_valid_i & vectorial_op & in_ready_o;  // Only when lane 0 accepts

  // Lane 1 drains only when lane 0 presents a vectorial item
  assign lane1_out_ready = out_ready_i & lane0_aux.vectorial;

  noncomp_lane #(
    .Fp32Enable ( 1'b1 )
  ) i_lane0 (
    .clk_i       ( clk_i             ),
    .rst_n_i     ( rst_n_i           ),
    .op_a_i      ( operand_a_i       ),
    .op_b_i      ( operand_b_i       ),
    .op_i        ( op_i              ),
    .fmt_i       ( fmt_i             ),
    .aux_i       ( in_aux            ),
    .in_valid_i  ( in_valid_i        ),
    .flush_i     ( flush_i           ),
    .out_ready_i ( out_ready_i       ),
    .in_ready_o  ( in_ready_o        ),  // Upstream ready is lane 0's
    .result_o    ( lane_result[0]    ),
    .status_o    ( lane_status[0]    ),
    .aux_o       ( lane0_aux         ),
    .out_valid_o ( lane_out_valid[0] ),
    .busy_o      ( lane_busy[0]      )
  );

  // Its ready is never needed as it only holds items that lane 0 accepted
  noncomp_lane #(
    .Fp32Enable ( 1'b0 )
  ) i_lane1 (
    .clk_i       ( clk_i             ),
    .rst_n_i     ( rst_n_i           ),
    .op_a_i      ( lane1_op_a        ),
    .op_b_i      ( lane1_op_b        ),
    .op_i        ( op_i              ),
    .fmt_i       ( fp_fmt_pkg::FP16  ),
    .aux_i       ( in_aux            ),
    .in_valid_i  ( lane1_in_valid    ),
    .flush_i     ( flush_i           ),
    .out_ready_i ( lane1_out_ready   ),
    .in_ready_o  (                   ),
    .result_o    ( lane_result[1]    ),
    .status_o    ( lane_status[1]    ),
    .aux_o       (                   ),
    .out_valid_o ( lane_out_valid[1] ),
    .busy_o      ( lane_busy[1]      )
  );

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  result_packer i_packer (
    .lane0_result_i ( lane_result[0]                          ),
    .lane1_result_i ( lane_result[1]                          ),
    .lane0_status_i ( lane_status[0]                          ),
    .lane1_status_i ( lane_status[1]                          ),
    .lane1_valid_i  ( lane_out_valid[1] & lane0_aux.vectorial ),
    .aux_i          ( lane0_aux                               ),
    .result_o       ( result_o                                ),
    .status_o       ( status_o                                )
  );

  assign tag_o       = lane0_aux.tag;
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

// ==== verilog/fp_op_pkg.sv ====
`include "fpu_slice_params.svh"

package fp_op_pkg;

  // --------------------------------------------------------------------------
  // Non-computational operations
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,  // Sign of B
    SGNJN = 3'd1,  // Inverted sign of B
    SGNJX = 3'd2,  // Sign of A xor sign of B
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } noncomp_op_e;

  // --------------------------------------------------------------------------
  // Data that follows an operation through lane 0
  // --------------------------------------------------------------------------
  typedef struct packed {
    fp_fmt_pkg::fp_format_e  fmt;        // Result format
    logic                    vectorial;  // Both lanes carry this item
    logic [`TAG_WIDTH-1:0]   tag;
  } slice_aux_t;

endpackage

// ==== verilog/lane_pipeline.sv ====
`timescale 1ns/1ps

`include "fpu_slice_params.svh"

module lane_pipeline #(
  parameter int unsigned DataWidth = `SLICE_WIDTH,
  parameter int unsigned NumStages = `NUM_PIPE_REGS
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  input  logic [DataWidth-1:0] in_data_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  input  logic                 out_ready_i,
  output logic                 out_valid_o,
  output logic [DataWidth-1:0] out_data_o,
  output logic                 busy_o
);

  // Index i is the item after i register stages
  logic [0:NumStages][DataWidth-1:0] stage_data;
  logic [0:NumStages]                stage_valid;
  logic [0:NumStages]                stage_ready;

  assign stage_data[0]  = in_data_i;
  assign stage_valid[0] = in_valid_i;

  // --------------------------------------------------------------------------
  // Register stages
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < int'(NumStages); i++) begin : gen_stage
    logic load_en;

    // Advance when the next stage moves on or holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;  // Drop everything in flight
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    assign load_en = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i) begin
      if (load_en) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Ready comes back from the downstream side
  assign stage_ready[NumStages] = out_ready_i;

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = stage_valid[NumStages];
  assign out_data_o  = stage_data[NumStages];

  if (NumStages > 0) begin : gen_busy
    assign busy_o = |stage_valid[1:NumStages];
  end else begin : gen_no_busy
    assign busy_o = in_valid_i;  // Nothing is ever stored
  end

endmodule

// ==== verilog/noncomp_lane.sv ====
`timescale 1ns/1ps

`include "fpu_slice_params.svh"

module noncomp_lane #(
  parameter bit Fp32Enable = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fp_fmt_pkg::fp_word_u     op_a_i,
  input  fp_fmt_pkg::fp_word_u     op_b_i,
  input  fp_op_pkg::noncomp_op_e   op_i,
  input  fp_fmt_pkg::fp_format_e   fmt_i,
  input  fp_op_pkg::slice_aux_t    aux_i,
  input  logic                     in_valid_i,
  input  logic                     flush_i,
  input  logic                     out_ready_i,
  output logic                     in_ready_o,
  output fp_fmt_pkg::fp_word_u     result_o,
  output fp_fmt_pkg::fp_status_t   status_o,
  output fp_op_pkg::slice_aux_t    aux_o,
  output logic                     out_valid_o,
  output logic                     busy_o
);

  localparam int unsigned DataWidth = `SLICE_WIDTH + $bits(fp_fmt_pkg::fp_status_t)
                                      + $bits(fp_op_pkg::slice_aux_t);

  logic                             is_fp32;
  fp_fmt_pkg::fp_word_u [1:0]       opnd;     // Operands with unused bits cleared
  logic [1:0]                       sign, nan, snan;
  logic [1:0][30:0]                 mag;
  logic                             a_lt_b;
  fp_fmt_pkg::fp_word_u             op_result;
  fp_fmt_pkg::fp_status_t           op_status;
  logic [DataWidth-1:0]             pipe_in_data, pipe_out_data;

  // --------------------------------------------------------------------------
  // Operand classification
  // --------------------------------------------------------------------------
  assign is_fp32 = Fp32Enable && (fmt_i == fp_fmt_pkg::FP32);  // FP32 path only when built
  assign opnd[0] = is_fp32 ? op_a_i : {16'h0000, op_a_i[15:0]};
  assign opnd[1] = is_fp32 ? op_b_i : {16'h0000, op_b_i[15:0]};

  always_comb begin : classify
    for (int i = 0; i < 2; i++) begin
      if (is_fp32) begin
        sign[i] = opnd[i].single.sign;
        mag[i]  = opnd[i][30:0];
        nan[i]  = (&opnd[i].single.exponent) & (|opnd[i].single.mantissa);
        snan[i] = nan[i] & ~opnd[i].single.mantissa[22];  // Quiet bit clear
      end else begin
        sign[i] = opnd[i].half[0].sign;
        mag[i]  = 31'(opnd[i][14:0]);
        nan[i]  = (&opnd[i].half[0].exponent) & (|opnd[i].half[0].mantissa);
        snan[i] = nan[i] & ~opnd[i].half[0].mantissa[9];
      end
    end
  end

  // Sign-magnitude compare, so -0 sorts below +0
  assign a_lt_b = (sign[0] != sign[1]) ? sign[0]
                : (sign[0] ? (mag[0] > mag[1]) : (mag[0] < mag[1]));

  // --------------------------------------------------------------------------
  // Sign injection and min/max
  // --------------------------------------------------------------------------
  always_comb begin : compute
    logic new_sign;
    case (op_i)
      fp_op_pkg::SGNJ:  new_sign = sign[1];
      fp_op_pkg::SGNJN: new_sign = ~sign[1];
      fp_op_pkg::SGNJX: new_sign = sign[0] ^ sign[1];
      default:          new_sign = sign[0];
    endcase
    op_status = '0;
    op_result = opnd[0];
    if (op_i == fp_op_pkg::FMIN || op_i == fp_op_pkg::FMAX) begin
      op_status.nv = |snan;
      if (&nan) begin
        op_result = is_fp32 ? fp_fmt_pkg::QNAN_FP32 : {16'h0000, fp_fmt_pkg::QNAN_FP16};
      end else if (nan[0]) begin
        op_result = opnd[1];  // The number wins over a NaN
      end else if (nan[1]) begin
        op_result = opnd[0];
      end else if (a_lt_b ^ (op_i == fp_op_pkg::FMAX)) begin
        op_result = opnd[0];
      end else begin
        op_result = opnd[1];
      end
    end else if (is_fp32) begin
      op_result.single.sign = new_sign;  // Payload of A is kept
    end else begin
      op_result.half[0].sign = new_sign;
    end
  end

  // Result, flags and aux move through the stages as one item
  assign pipe_in_data = {op_result, op_status, aux_i};

  lane_pipeline #(
    .DataWidth ( DataWidth      ),
    .NumStages ( `NUM_PIPE_REGS )
  ) i_pipeline (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .in_valid_i  ( in_valid_i    ),
    .in_data_i   ( pipe_in_data  ),
    .in_ready_o  ( in_ready_o    ),
    .flush_i     ( flush_i       ),
    .out_ready_i ( out_ready_i   ),
    .out_valid_o ( out_valid_o   ),
    .out_data_o  ( pipe_out_data ),
    .busy_o      ( busy_o        )
  );

  assign {result_o, status_o, aux_o} = pipe_out_data;

endmodule

// ==== verilog/result_packer.sv ====
`timescale 1ns/1ps

`include "fpu_slice_params.svh"

module result_packer (
  input  fp_fmt_pkg::fp_word_u    lane0_result_i,
  input  fp_fmt_pkg::fp_word_u    lane1_result_i,
  input  fp_fmt_pkg::fp_status_t  lane0_status_i,
  input  fp_fmt_pkg::fp_status_t  lane1_status_i,
  input  logic                    lane1_valid_i,
  input  fp_op_pkg::slice_aux_t   aux_i,
  output fp_fmt_pkg::fp_word_u    result_o,
  output fp_fmt_pkg::fp_status_t  status_o
);

  localparam int unsigned HalfWidth = `SLICE_WIDTH / 2;

  logic                    use_lane1;
  logic [HalfWidth-1:0]    upper_half;
  fp_fmt_pkg::fp_status_t  lane1_status;

  // --------------------------------------------------------------------------
  // Result packing
  // --------------------------------------------------------------------------

  // Upper FP16 half only comes from lane 1 for a vectorial item it holds
  assign use_lane1 = aux_i.vectorial & lane1_valid_i;

  // Scalar FP16 results get their unused upper half NaN-boxed
  assign upper_half = use_lane1 ? lane1_result_i.half[0] : '1;

  always_comb begin : pack
    result_o = lane0_result_i;  // FP32 uses the whole lane 0 word
    if (aux_i.fmt == fp_fmt_pkg::FP16) begin
      result_o.half[1] = upper_half;
    end
  end

  // --------------------------------------------------------------------------
  // Status collapse
  // --------------------------------------------------------------------------
  assign lane1_status = lane1_valid_i ? lane1_status_i : '0;  // Idle lane adds nothing

  assign status_o = lane0_status_i | lane1_status;

endmodule
